//--- src/modexp_pkg.sv
// default operand sizes and the enums shared by the modexp engine
`default_nettype none

package modexp_pkg;

	parameter int DEFAULT_WORD_W = 16;	// bits per word
	parameter int DEFAULT_NUM_WORDS = 2;	// words per operand

	typedef enum logic [3:0] {
		LOAD_IDLE,	// waiting for a full key load
		LOAD_KEY,	// e, r, t, n words
		LOAD_MSG,	// m words
		WAIT_COMPUTE,
		TO_MONT,	// m_bar = MonPro(m, t)
		FIND_LEAD,	// scan e for its leading one
		SQUARE,
		MULTIPLY,
		FROM_MONT,	// c = MonPro(1, c_bar)
		COMPLETE,
		OUTPUT,
		MSG_IDLE	// key kept, waiting for a new message
	} exp_state_t;

	typedef enum logic [1:0] {
		OP_TO_MONT,	// m * t into m_bar, r into c_bar
		OP_SQUARE,	// c_bar * c_bar into c_bar
		OP_MUL,	// c_bar * m_bar into c_bar
		OP_FROM_MONT	// 1 * c_bar into c_bar
	} mp_op_t;

	typedef enum logic [2:0] {
		MP_MUL, MP_ACC_TOP, MP_QUOT, MP_RED, MP_RED_TOP, MP_CARRY, MP_SUB, MP_WRITE
	} mp_step_t;

endpackage

`default_nettype wire

//--- src/word_mac.sv
// registered word multiply-accumulate, {carry, sum} = x*y + z + cin
`default_nettype none

module word_mac #(
	parameter int word_w = modexp_pkg::DEFAULT_WORD_W
) (
	input  logic              clk,
	input  logic              reset,
	input  logic [word_w-1:0] x,
	input  logic [word_w-1:0] y,
	input  logic [word_w-1:0] z,
	input  logic [word_w-1:0] cin,
	output logic [word_w-1:0] sum,
	output logic [word_w-1:0] carry
);

	logic [2*word_w-1:0] prod;
	logic [2*word_w-1:0] acc;

	assign prod = {{word_w{1'b0}}, x} * {{word_w{1'b0}}, y};
	assign acc = prod + {{word_w{1'b0}}, z} + {{word_w{1'b0}}, cin};	// never overflows 2w bits

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			sum <= '0;
			carry <= '0;
		end else begin
			sum <= acc[word_w-1:0];
			carry <= acc[2*word_w-1:word_w];
		end
	end

endmodule

`default_nettype wire

//--- src/mon_pro.sv
// word-serial CIOS Montgomery product a*b/R mod n on one shared word mac
// ends with a trial subtraction of n and a word-by-word write-back
`default_nettype none

module mon_pro #(
	parameter int word_w = modexp_pkg::DEFAULT_WORD_W,
	parameter int num_words = modexp_pkg::DEFAULT_NUM_WORDS,
	localparam int idx_w = (num_words > 1) ? $clog2(num_words) : 1
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              mp_start,
	input  logic [word_w-1:0] a_word,
	input  logic [word_w-1:0] b_word,
	input  logic [word_w-1:0] n_word,
	input  logic [word_w-1:0] n_prime0,
	output logic              mp_done,
	output logic [idx_w-1:0]  a_idx,
	output logic [idx_w-1:0]  b_idx,
	output logic [idx_w-1:0]  n_idx,
	output logic [idx_w-1:0]  wb_idx,
	output logic              wb_we,
	output logic [word_w-1:0] wb_word
);
	import modexp_pkg::*;

	localparam logic [idx_w-1:0] last_idx = idx_w'(num_words - 1);

	mp_step_t step;
	logic active;
	logic phase;	// 0 presents mac operands, 1 takes the result
	logic mac_step;
	logic [idx_w-1:0] out_i;
	logic [idx_w-1:0] in_j;
	logic [idx_w-1:0] next_j;
	logic j_last;
	logic [word_w-1:0] v [num_words+2];	// scratch t[0..s+1]
	logic [word_w-1:0] diff [num_words];
	logic [word_w-1:0] c_reg;
	logic [word_w-1:0] q_reg;	// reduction quotient for this outer word
	logic borrow;
	logic keep_diff;
	logic [word_w:0] acc_top;
	logic [word_w:0] sub_w;
	logic [word_w-1:0] mac_x, mac_y, mac_z, mac_cin;
	logic [word_w-1:0] mac_sum, mac_carry;

	word_mac #(.word_w(word_w)) u_mac (
		.clk(clk), .reset(reset),
		.x(mac_x), .y(mac_y), .z(mac_z), .cin(mac_cin),
		.sum(mac_sum), .carry(mac_carry)
	);

	assign j_last = (in_j == last_idx);
	assign next_j = j_last ? '0 : in_j + 1'b1;
	assign mac_step = (step == MP_MUL) || (step == MP_QUOT) || (step == MP_RED) ||
		(step == MP_RED_TOP);
	assign acc_top = {1'b0, v[num_words]} + {1'b0, c_reg};
	assign sub_w = {1'b0, v[in_j]} - {1'b0, n_word} - {{word_w{1'b0}}, borrow};
	assign keep_diff = !borrow || (v[num_words] != '0);	// value >= n

	assign a_idx = out_i;
	assign b_idx = in_j;
	assign n_idx = in_j;
	assign wb_idx = in_j;
	assign wb_we = active && (step == MP_WRITE);
	assign wb_word = keep_diff ? diff[in_j] : v[in_j];
	assign mp_done = wb_we && j_last;

	always_comb begin
		mac_x = '0;
		mac_y = '0;
		mac_z = '0;
		mac_cin = '0;
		case (step)
			MP_MUL: begin	// t[j] + a[i]*b[j] + C
				mac_x = a_word;
				mac_y = b_word;
				mac_z = v[in_j];
				mac_cin = c_reg;
			end
			MP_QUOT: begin	// q = t[0]*n0' mod 2^w
				mac_x = v[0];
				mac_y = n_prime0;
			end
			MP_RED: begin
				mac_x = q_reg;
				mac_y = n_word;
				mac_z = v[in_j];
				mac_cin = (in_j == '0) ? '0 : c_reg;
			end
			MP_RED_TOP: begin
				mac_z = v[num_words];
				mac_cin = c_reg;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			active <= 1'b0;
			step <= MP_MUL;
			phase <= 1'b0;
			out_i <= '0;
			in_j <= '0;
		end else if (!active) begin
			if (mp_start) begin
				active <= 1'b1;
				step <= MP_MUL;
				phase <= 1'b0;
				out_i <= '0;
				in_j <= '0;
			end
		end else begin
			phase <= mac_step ? ~phase : 1'b0;
			case (step)
				MP_MUL, MP_RED: begin
					if (phase) begin
						in_j <= next_j;
						if (j_last)
							step <= (step == MP_MUL) ? MP_ACC_TOP : MP_RED_TOP;
					end
				end
				MP_ACC_TOP: step <= MP_QUOT;
				MP_QUOT: begin
					if (phase)
						step <= MP_RED;
				end
				MP_RED_TOP: begin
					if (phase)
						step <= MP_CARRY;
				end
				MP_CARRY: begin	// next outer word or finish
					out_i <= (out_i == last_idx) ? '0 : out_i + 1'b1;
					step <= (out_i == last_idx) ? MP_SUB : MP_MUL;
				end
				MP_SUB: begin
					in_j <= next_j;
					if (j_last)
						step <= MP_WRITE;
				end
				MP_WRITE: begin
					in_j <= next_j;
					if (j_last)
						active <= 1'b0;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (mp_start && !active) begin
			for (int k = 0; k < num_words + 2; k++)
				v[k] <= '0;
			c_reg <= '0;
		end else if (active) begin
			case (step)
				MP_MUL: begin
					if (phase) begin
						v[in_j] <= mac_sum;
						c_reg <= mac_carry;
					end
				end
				MP_ACC_TOP: begin
					v[num_words] <= acc_top[word_w-1:0];
					v[num_words+1] <= word_w'(acc_top[word_w]);
				end
				MP_QUOT: begin
					if (phase)
						q_reg <= mac_sum;
				end
				MP_RED: begin
					if (phase) begin
						c_reg <= mac_carry;
						if (in_j != '0)
							v[in_j - 1'b1] <= mac_sum;	// shift down one word
					end
				end
				MP_RED_TOP: begin
					if (phase) begin
						v[num_words-1] <= mac_sum;
						c_reg <= mac_carry;
					end
				end
				MP_CARRY: begin
					v[num_words] <= v[num_words+1] + c_reg;
					c_reg <= '0;
					borrow <= 1'b0;
				end
				MP_SUB: begin
					diff[in_j] <= sub_w[word_w-1:0];
					borrow <= sub_w[word_w];
				end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/operand_store.sv
// operand word memories e, r, t, n, m, m_bar and c_bar
// operand pair select for each MonPro opcode and the write-back routing
`default_nettype none

module operand_store #(
	parameter int word_w = modexp_pkg::DEFAULT_WORD_W,
	parameter int num_words = modexp_pkg::DEFAULT_NUM_WORDS,
	localparam int idx_w = (num_words > 1) ? $clog2(num_words) : 1,
	localparam int bit_w = (word_w * num_words > 1) ? $clog2(word_w * num_words) : 1
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 load_key,
	input  logic                 load_msg,
	input  logic [idx_w-1:0]     load_idx,
	input  logic [word_w-1:0]    e_word,
	input  logic [word_w-1:0]    r_word,
	input  logic [word_w-1:0]    t_word,
	input  logic [word_w-1:0]    n_word_in,
	input  logic [word_w-1:0]    n_prime0_in,
	input  logic [word_w-1:0]    m_word,
	input  modexp_pkg::mp_op_t   mp_op,
	input  logic [idx_w-1:0]     a_idx,
	input  logic [idx_w-1:0]     b_idx,
	input  logic [idx_w-1:0]     n_idx,
	input  logic [bit_w-1:0]     bit_idx,
	input  logic                 wb_we,
	input  logic [idx_w-1:0]     wb_idx,
	input  logic [word_w-1:0]    wb_word,
	input  logic [idx_w-1:0]     res_idx,
	output logic [word_w-1:0]    a_word,
	output logic [word_w-1:0]    b_word,
	output logic [word_w-1:0]    n_word,
	output logic [word_w-1:0]    n_prime0,
	output logic                 e_bit,
	output logic [word_w-1:0]    res_word_raw
);
	import modexp_pkg::*;

	logic [word_w-1:0] e_mem [num_words];
	logic [word_w-1:0] r_mem [num_words];
	logic [word_w-1:0] t_mem [num_words];
	logic [word_w-1:0] n_mem [num_words];
	logic [word_w-1:0] m_mem [num_words];
	logic [word_w-1:0] mbar_mem [num_words];
	logic [word_w-1:0] cbar_mem [num_words];
	logic [word_w*num_words-1:0] e_flat;

	// exponent cleared on reset so an early compute gives 1 mod n
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int k = 0; k < num_words; k++)
				e_mem[k] <= '0;
			n_prime0 <= '0;
		end else if (load_key) begin
			e_mem[load_idx] <= e_word;
			if (load_idx == '0)
				n_prime0 <= n_prime0_in;	// only sampled with the first word
		end
	end

	always_ff @(posedge clk) begin
		if (load_key) begin
			r_mem[load_idx] <= r_word;
			t_mem[load_idx] <= t_word;
			n_mem[load_idx] <= n_word_in;
		end
		if (load_msg)
			m_mem[load_idx] <= m_word;
		if (wb_we) begin
			if (mp_op == OP_TO_MONT) begin
				mbar_mem[wb_idx] <= wb_word;
				cbar_mem[wb_idx] <= r_mem[wb_idx];	// c_bar starts as R mod n
			end else begin
				cbar_mem[wb_idx] <= wb_word;
			end
		end
	end

	always_comb begin
		for (int k = 0; k < num_words; k++)
			e_flat[k*word_w +: word_w] = e_mem[k];
	end

	always_comb begin
		case (mp_op)
			OP_TO_MONT: begin
				a_word = m_mem[a_idx];
				b_word = t_mem[b_idx];
			end
			OP_SQUARE: begin
				a_word = cbar_mem[a_idx];
				b_word = cbar_mem[b_idx];
			end
			OP_MUL: begin
				a_word = cbar_mem[a_idx];
				b_word = mbar_mem[b_idx];
			end
			default: begin	// the constant one, low word first
				a_word = (a_idx == '0) ? word_w'(1) : '0;
				b_word = cbar_mem[b_idx];
			end
		endcase
	end

	assign n_word = n_mem[n_idx];
	assign e_bit = e_flat[bit_idx];
	assign res_word_raw = cbar_mem[res_idx];

endmodule

`default_nettype wire

//--- src/exp_sequencer.sv
// host command FSM, load and readout counters, leading-one scan of e
// and left-to-right square-and-multiply issue of MonPro operations
`default_nettype none

module exp_sequencer #(
	parameter int word_w = modexp_pkg::DEFAULT_WORD_W,
	parameter int num_words = modexp_pkg::DEFAULT_NUM_WORDS,
	localparam int idx_w = (num_words > 1) ? $clog2(num_words) : 1,
	localparam int bit_w = (word_w * num_words > 1) ? $clog2(word_w * num_words) : 1
) (
	input  logic               clk,
	input  logic               reset,
	input  logic               start_input,
	input  logic               start_compute,
	input  logic               get_result,
	input  logic               e_bit,
	input  logic               mp_done,
	output logic               load_key,
	output logic               load_msg,
	output logic [idx_w-1:0]   load_idx,
	output logic [bit_w-1:0]   bit_idx,
	output logic               mp_start,
	output modexp_pkg::mp_op_t mp_op,
	output logic [idx_w-1:0]   res_idx,
	output logic               result_ready,
	output logic               res_valid
);
	import modexp_pkg::*;

	localparam logic [idx_w-1:0] last_idx = idx_w'(num_words - 1);
	localparam logic [bit_w-1:0] top_bit = bit_w'(word_w * num_words - 1);

	exp_state_t state;
	logic [idx_w-1:0] word_cnt;	// shared by loads and readout
	logic [idx_w-1:0] cnt_next;
	logic cnt_last;

	assign cnt_last = (word_cnt == last_idx);
	assign cnt_next = cnt_last ? '0 : word_cnt + 1'b1;
	assign load_key = (state == LOAD_KEY);
	assign load_msg = (state == LOAD_MSG);
	assign load_idx = word_cnt;
	assign res_idx = word_cnt;
	assign result_ready = (state == COMPLETE);
	assign res_valid = (state == OUTPUT);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= LOAD_IDLE;
			word_cnt <= '0;
			bit_idx <= '0;
			mp_start <= 1'b0;
			mp_op <= OP_TO_MONT;
		end else begin
			mp_start <= 1'b0;
			case (state)
				LOAD_IDLE: begin
					if (start_input)
						state <= LOAD_KEY;
				end
				LOAD_KEY: begin
					word_cnt <= cnt_next;
					if (cnt_last)
						state <= LOAD_MSG;
				end
				LOAD_MSG: begin
					word_cnt <= cnt_next;
					if (cnt_last)
						state <= WAIT_COMPUTE;
				end
				WAIT_COMPUTE: begin
					if (start_compute) begin
						state <= TO_MONT;
						mp_op <= OP_TO_MONT;
						mp_start <= 1'b1;
					end
				end
				TO_MONT: begin
					if (mp_done) begin
						state <= FIND_LEAD;
						bit_idx <= top_bit;
					end
				end
				FIND_LEAD: begin	// one bit per cycle from the top
					if (e_bit) begin
						state <= MULTIPLY;	// c_bar = R times m_bar
						mp_op <= OP_MUL;
						mp_start <= 1'b1;
					end else if (bit_idx == '0) begin
						state <= FROM_MONT;	// e is zero
						mp_op <= OP_FROM_MONT;
						mp_start <= 1'b1;
					end else begin
						bit_idx <= bit_idx - 1'b1;
					end
				end
				SQUARE: begin
					if (mp_done) begin
						mp_start <= 1'b1;
						if (e_bit) begin
							state <= MULTIPLY;
							mp_op <= OP_MUL;
						end else if (bit_idx == '0) begin
							state <= FROM_MONT;
							mp_op <= OP_FROM_MONT;
						end else begin
							bit_idx <= bit_idx - 1'b1;	// square again
							mp_op <= OP_SQUARE;
						end
					end
				end
				MULTIPLY: begin
					if (mp_done) begin
						mp_start <= 1'b1;
						if (bit_idx == '0) begin
							state <= FROM_MONT;
							mp_op <= OP_FROM_MONT;
						end else begin
							state <= SQUARE;
							bit_idx <= bit_idx - 1'b1;
							mp_op <= OP_SQUARE;
						end
					end
				end
				FROM_MONT: begin
					if (mp_done)
						state <= COMPLETE;
				end
				COMPLETE: begin
					if (get_result)
						state <= OUTPUT;
				end
				OUTPUT: begin
					word_cnt <= cnt_next;
					if (cnt_last)
						state <= MSG_IDLE;
				end
				MSG_IDLE: begin	// key kept, only m is reloaded
					if (start_input)
						state <= LOAD_MSG;
				end
				default: state <= LOAD_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/modexp_top.sv
// modexp engine top, operand store, sequencer and Montgomery product unit
`default_nettype none

module modexp_top #(
	parameter int word_w = modexp_pkg::DEFAULT_WORD_W,
	parameter int num_words = modexp_pkg::DEFAULT_NUM_WORDS,
	localparam int idx_w = (num_words > 1) ? $clog2(num_words) : 1,
	localparam int bit_w = (word_w * num_words > 1) ? $clog2(word_w * num_words) : 1
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              start_input,
	input  logic              start_compute,
	input  logic              get_result,
	input  logic [word_w-1:0] e_word,
	input  logic [word_w-1:0] r_word,
	input  logic [word_w-1:0] t_word,
	input  logic [word_w-1:0] n_word,
	input  logic [word_w-1:0] n_prime0,
	input  logic [word_w-1:0] m_word,
	output logic              result_ready,
	output logic              res_valid,
	output logic [word_w-1:0] res_word
);
	import modexp_pkg::*;

	logic load_key, load_msg, e_bit, mp_start, mp_done, wb_we, out_valid;
	logic [idx_w-1:0] load_idx, a_idx, b_idx, n_idx, wb_idx, res_idx;
	logic [bit_w-1:0] bit_idx;
	logic [word_w-1:0] a_word, b_word, mp_n_word, np0_word, wb_word, res_word_raw;
	mp_op_t mp_op;

	operand_store #(.word_w(word_w), .num_words(num_words)) u_store (
		.clk(clk), .reset(reset), .load_key(load_key), .load_msg(load_msg),
		.load_idx(load_idx), .e_word(e_word), .r_word(r_word), .t_word(t_word),
		.n_word_in(n_word), .n_prime0_in(n_prime0), .m_word(m_word), .mp_op(mp_op),
		.a_idx(a_idx), .b_idx(b_idx), .n_idx(n_idx), .bit_idx(bit_idx),
		.wb_we(wb_we), .wb_idx(wb_idx), .wb_word(wb_word), .res_idx(res_idx),
		.a_word(a_word), .b_word(b_word), .n_word(mp_n_word), .n_prime0(np0_word),
		.e_bit(e_bit), .res_word_raw(res_word_raw)
	);

	exp_sequencer #(.word_w(word_w), .num_words(num_words)) u_seq (
		.clk(clk), .reset(reset), .start_input(start_input),
		.start_compute(start_compute), .get_result(get_result), .e_bit(e_bit),
		.mp_done(mp_done), .load_key(load_key), .load_msg(load_msg),
		.load_idx(load_idx), .bit_idx(bit_idx), .mp_start(mp_start), .mp_op(mp_op),
		.res_idx(res_idx), .result_ready(result_ready), .res_valid(out_valid)
	);

	mon_pro #(.word_w(word_w), .num_words(num_words)) u_mon_pro (
		.clk(clk), .reset(reset), .mp_start(mp_start), .a_word(a_word),
		.b_word(b_word), .n_word(mp_n_word), .n_prime0(np0_word), .mp_done(mp_done),
		.a_idx(a_idx), .b_idx(b_idx), .n_idx(n_idx), .wb_idx(wb_idx),
		.wb_we(wb_we), .wb_word(wb_word)
	);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			res_valid <= 1'b0;
			res_word <= '0;
		end else begin
			res_valid <= out_valid;
			res_word <= out_valid ? res_word_raw : '0;	// bus idles at zero
		end
	end

endmodule

`default_nettype wire

//--- dv/modexp_assert.sv
// concurrent assertions on the modexp result port, attached to modexp_top by bind
`default_nettype none

module modexp_assert #(
	parameter int word_w = modexp_pkg::DEFAULT_WORD_W,
	parameter int num_words = modexp_pkg::DEFAULT_NUM_WORDS
) (
	input logic              clk,
	input logic              reset,
	input logic              get_result,
	input logic              result_ready,
	input logic              res_valid,
	input logic [word_w-1:0] res_word
);
	timeunit 1ns;
	timeprecision 1ps;

	int run_len;	// length of the current res_valid burst

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			run_len <= 0;
		else if (res_valid)
			run_len <= run_len + 1;
		else
			run_len <= 0;
	end

	a_word_idle_zero: assert property (@(posedge clk) disable iff (reset)
		!res_valid |-> (res_word == '0))
		else $error("res_word nonzero while res_valid is low");

	a_burst_length: assert property (@(posedge clk) disable iff (reset)
		$fell(res_valid) |-> ($past(run_len) + 1 == num_words))
		else $error("res_valid burst length differs from num_words");

	a_burst_bound: assert property (@(posedge clk) disable iff (reset)
		res_valid |-> (run_len < num_words))
		else $error("res_valid held longer than num_words cycles");

	a_readout_start: assert property (@(posedge clk) disable iff (reset)
		(get_result && result_ready) |-> ##2 res_valid)
		else $error("accepted get_result not followed by res_valid");

	a_ready_off_in_output: assert property (@(posedge clk) disable iff (reset)
		res_valid |-> !result_ready)
		else $error("result_ready high during readout");

endmodule

bind modexp_top modexp_assert #(.word_w(word_w), .num_words(num_words)) u_assert (
	.clk(clk), .reset(reset), .get_result(get_result), .result_ready(result_ready),
	.res_valid(res_valid), .res_word(res_word)
);

`default_nettype wire

//--- dv/modexp_checker.sv
// reference m^e mod n model, readout comparison per test and the closing count
`default_nettype none

module modexp_checker #(
	parameter int word_w = modexp_pkg::DEFAULT_WORD_W,
	parameter int num_words = modexp_pkg::DEFAULT_NUM_WORDS
) (
	input logic              clk,
	input logic              reset,
	input logic              get_result,
	input logic              result_ready,
	input logic              res_valid,
	input logic [word_w-1:0] res_word
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int op_w = word_w * num_words;	// model holds operands up to 32 bits

	logic [word_w-1:0] exp_words [num_words];
	string test_name;
	logic pending;	// a test is waiting for its readout
	logic armed;	// get_result accepted and words on their way
	logic rr_prev;
	logic accept_prev;
	logic test_bad;
	int got;
	int n_done;
	int n_fail;
	int n_other;

	initial begin
		pending = 1'b0;
		armed = 1'b0;
		rr_prev = 1'b0;
		accept_prev = 1'b0;
		test_bad = 1'b0;
		got = 0;
		n_done = 0;
		n_fail = 0;
		n_other = 0;
	end

	// left-to-right square-and-multiply on plain integers
	function automatic logic [63:0] mod_pow(input logic [63:0] m, input logic [63:0] e,
			input logic [63:0] n);
		logic [63:0] acc;
		acc = 64'd1 % n;
		for (int i = op_w - 1; i >= 0; i--) begin
			acc = (acc * acc) % n;
			if (e[i])
				acc = (acc * m) % n;
		end
		return acc;
	endfunction

	task automatic expect_result(input string name, input logic [63:0] m,
			input logic [63:0] e, input logic [63:0] n);
		logic [63:0] pw;
		pw = mod_pow(m, e, n);
		for (int k = 0; k < num_words; k++)
			exp_words[k] = pw[k*word_w +: word_w];
		test_name = name;
		test_bad = 1'b0;
		got = 0;
		pending = 1'b1;
	endtask

	task automatic flag_failure(input string msg);
		$display("%s", msg);
		n_other++;
		if (pending) begin	// the test ends here without a result
			n_done++;
			n_fail++;
			$display("test %s: no result", test_name);
			pending = 1'b0;
			armed = 1'b0;
		end
	endtask

	function automatic int error_count();
		return n_fail + n_other;
	endfunction

	function automatic int tests_done();
		return n_done;
	endfunction

	task automatic report();
		$display("tests %0d, passed %0d, failed %0d, other errors %0d",
			n_done, n_done - n_fail, n_fail, n_other);
	endtask

	always @(posedge clk) begin
		if (!reset) begin
			if (res_valid) begin
				if (!armed) begin
					$display("res_valid high without an accepted get_result");
					n_other++;
				end else begin
					if (res_word !== exp_words[got]) begin
						$display("Error res_word[%0d]: expected %h, got %h",
							got, exp_words[got], res_word);
						test_bad = 1'b1;
					end
					got++;
					if (got == num_words) begin
						n_done++;
						if (test_bad)
							n_fail++;
						$display("test %s: %s", test_name, test_bad ? "mismatch" : "ok");
						armed = 1'b0;
						pending = 1'b0;
					end
				end
			end
			// result_ready only falls after an accepted get_result
			if (rr_prev && !result_ready && !accept_prev) begin
				$display("result_ready dropped without get_result");
				n_other++;
			end
			if (get_result && result_ready) begin
				armed = 1'b1;
				got = 0;
			end
			accept_prev = get_result && result_ready;
			rr_prev = result_ready;
		end
	end

endmodule

`default_nettype wire

//--- dv/tb_top.sv
// modexp testbench top with clock, reset, watchdog, random operands and host stimulus
`default_nettype none

module tb_top;
	timeunit 1ns;
	timeprecision 1ps;
	import modexp_pkg::*;

	localparam int word_w = DEFAULT_WORD_W;
	localparam int num_words = DEFAULT_NUM_WORDS;
	localparam int op_w = word_w * num_words;
	localparam int n_tests = 9;
	localparam int mp_cycles = num_words * (4 * num_words + 6) + num_words + 2;
	localparam int worst_ops = 2 * op_w + 2;	// MonPro calls per exponentiation
	localparam int test_cycles = mp_cycles * worst_ops + 200;
	localparam longint limit_ns = longint'(n_tests) * test_cycles * 2 * 4 + 4000;
	localparam logic [63:0] op_mask = (op_w >= 64) ? '1 : ((64'd1 << op_w) - 1);
	localparam logic [63:0] word_mask = (64'd1 << word_w) - 1;

	logic clk;
	logic reset;
	logic start_input;
	logic start_compute;
	logic get_result;
	logic [word_w-1:0] e_word;
	logic [word_w-1:0] r_word;
	logic [word_w-1:0] t_word;
	logic [word_w-1:0] n_word;
	logic [word_w-1:0] n_prime0;
	logic [word_w-1:0] m_word;
	logic result_ready;
	logic res_valid;
	logic [word_w-1:0] res_word;

	logic [63:0] key_e;	// key kept in the DUT between messages
	logic [63:0] key_n;

	modexp_top #(.word_w(word_w), .num_words(num_words)) u_dut (
		.clk(clk), .reset(reset), .start_input(start_input),
		.start_compute(start_compute), .get_result(get_result), .e_word(e_word),
		.r_word(r_word), .t_word(t_word), .n_word(n_word), .n_prime0(n_prime0),
		.m_word(m_word), .result_ready(result_ready), .res_valid(res_valid),
		.res_word(res_word)
	);

	modexp_checker #(.word_w(word_w), .num_words(num_words)) u_chk (
		.clk(clk), .reset(reset), .get_result(get_result),
		.result_ready(result_ready), .res_valid(res_valid), .res_word(res_word)
	);

	always #2 clk = ~clk;

	// -n^-1 mod 2^w by Newton iteration doubling the correct bits per step
	function automatic logic [63:0] neg_inv_word(input logic [63:0] n);
		logic [63:0] inv;
		inv = n;	// right to 3 bits for odd n
		for (int k = 0; k < 6; k++)
			inv = inv * (64'd2 - n * inv);
		return (-inv) & word_mask;
	endfunction

	function automatic logic [63:0] draw_wide();
		logic [63:0] v;
		v = {32'($urandom()), 32'($urandom())};
		return v & op_mask;
	endfunction

	// only LOAD_IDLE takes a new key
	task automatic reset_dut();
		@(posedge clk);
		reset <= 1'b1;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
	endtask

	task automatic send_message(input logic [63:0] m);
		for (int i = 0; i < num_words; i++) begin
			@(posedge clk);
			start_input <= 1'b0;
			m_word <= m[i*word_w +: word_w];
		end
		@(posedge clk);	// last word captured here
	endtask

	task automatic load_key_and_msg(input logic [63:0] e, input logic [63:0] n,
			input logic [63:0] m);
		logic [63:0] r;
		logic [63:0] t;
		logic [63:0] np0;
		r = (64'd1 << op_w) % n;
		t = (r * r) % n;
		np0 = neg_inv_word(n);
		key_e = e;
		key_n = n;
		@(posedge clk);
		start_input <= 1'b1;
		for (int i = 0; i < num_words; i++) begin
			@(posedge clk);
			start_input <= 1'b0;
			e_word <= e[i*word_w +: word_w];
			r_word <= r[i*word_w +: word_w];
			t_word <= t[i*word_w +: word_w];
			n_word <= n[i*word_w +: word_w];
			n_prime0 <= np0[word_w-1:0];
		end
		send_message(m);
	endtask

	task automatic load_msg_only(input logic [63:0] m);
		@(posedge clk);
		start_input <= 1'b1;
		send_message(m);
	endtask

	// stray pulses are mixed in around the accepted ones
	task automatic compute_and_read(input string name, input logic [63:0] m);
		int cnt;
		u_chk.expect_result(name, m, key_e, key_n);
		@(posedge clk);
		get_result <= 1'b1;	// ignored in WAIT_COMPUTE
		@(posedge clk);
		get_result <= 1'b0;
		@(posedge clk);
		start_compute <= 1'b1;
		@(posedge clk);
		start_compute <= 1'b0;
		get_result <= 1'b1;	// ignored while computing
		@(posedge clk);
		get_result <= 1'b0;
		start_compute <= 1'b1;
		@(posedge clk);
		start_compute <= 1'b0;
		cnt = 0;
		while (!result_ready && cnt < test_cycles) begin
			@(negedge clk);
			cnt++;
		end
		if (!result_ready) begin
			u_chk.flag_failure($sformatf("test %s: result_ready never rose", name));
			return;
		end
		@(posedge clk);
		start_compute <= 1'b1;	// ignored in COMPLETE
		@(posedge clk);
		start_compute <= 1'b0;
		get_result <= 1'b1;
		@(posedge clk);
		get_result <= 1'b0;
		cnt = 0;
		while (u_chk.pending && cnt < 4 * num_words + 8) begin
			@(negedge clk);
			cnt++;
		end
		if (u_chk.pending)
			u_chk.flag_failure($sformatf("test %s: readout did not complete", name));
	endtask

	task automatic run_key_test(input string name, input logic [63:0] e);
		logic [63:0] n;
		logic [63:0] m;
		n = draw_wide() | 64'd1 | (64'd1 << (op_w - 1));	// odd, top bit set
		m = draw_wide() % n;
		reset_dut();
		load_key_and_msg(e & op_mask, n, m);
		compute_and_read(name, m);
	endtask

	initial begin
		logic [63:0] m;
		clk = 1'b0;
		reset = 1'b1;
		start_input = 1'b0;
		start_compute = 1'b0;
		get_result = 1'b0;
		e_word = '0;
		r_word = '0;
		t_word = '0;
		n_word = '0;
		n_prime0 = '0;
		m_word = '0;
		void'($urandom(32'h3940));
		repeat (3) @(posedge clk);
		reset <= 1'b0;

		run_key_test("random_e_0", draw_wide());
		run_key_test("random_e_1", draw_wide());
		run_key_test("random_e_2", draw_wide());
		run_key_test("e_zero", 64'd0);
		run_key_test("e_one", 64'd1);
		run_key_test("e_top_bit", 64'd1 << (op_w - 1));
		run_key_test("reuse_key", draw_wide());
		m = draw_wide() % key_n;
		load_msg_only(m);
		compute_and_read("reuse_msg_0", m);
		m = draw_wide() % key_n;
		load_msg_only(m);
		compute_and_read("reuse_msg_1", m);

		repeat (4) @(posedge clk);
		u_chk.report();
		if (u_chk.error_count() == 0 && u_chk.tests_done() == n_tests) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	initial begin
		#(limit_ns);
		$display("watchdog expired after %0d ns, run stopped", limit_ns);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- compile.f
src/modexp_pkg.sv
src/word_mac.sv
src/mon_pro.sv
src/operand_store.sv
src/exp_sequencer.sv
src/modexp_top.sv
dv/modexp_assert.sv
dv/modexp_checker.sv
dv/tb_top.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the modexp testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f compile.f -o sim_tb \
	&& ./obj_dir/sim_tb | tee /dev/stderr | grep -q "Simulation finished: PASS" \
	&& exit 0 \
	|| exit 1
